//--- source/mipsCore_config.svh
`ifndef MIPSCORE_CONFIG_SVH
`define MIPSCORE_CONFIG_SVH

// datapath width, only 32 is supported
`define DATA_W      32
`define REG_ADDR_W  5
`define REG_NUM     32
`define REG_LINK    5'd31   // jal destination

// exception codes carried in the writeback record
`define EXC_NONE    2'd0
`define EXC_OVF     2'd1
`define EXC_RI      2'd2

`endif

//--- source/mipsIsaPkg.sv
`default_nettype none

`include "mipsCore_config.svh"

package mipsIsaPkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASSB
    } aluOp_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_JUMP, BR_JREG
    } brCond_e;

    typedef struct packed {
        opcode_e                op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        funct_e                 funct;
    } rType_s;

    typedef struct packed {
        opcode_e                op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm16;
    } iType_s;

    // one instruction word, two views
    typedef union packed {
        rType_s r;
        iType_s i;
    } instWord_u;

endpackage

`default_nettype wire

//--- source/pipeStagePkg.sv
`default_nettype none

`include "mipsCore_config.svh"

package pipeStagePkg;

    // decode -> execute
    typedef struct packed {
        logic [`DATA_W-1:0]     pc;
        logic [`DATA_W-1:0]     opA;      // forwarded rs
        logic [`DATA_W-1:0]     opB;      // rt or extended imm
        logic [`DATA_W-1:0]     rtVal;    // forwarded rt, for compares
        mipsIsaPkg::aluOp_e     aluOp;
        mipsIsaPkg::brCond_e    brCond;
        logic [4:0]             shamt;
        logic [25:0]            jIndex;
        logic [15:0]            imm16;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   regWrite;
        logic                   link;     // write pc+8 instead of alu result
        logic                   ovfCheck;
        logic                   riFlag;
        logic                   valid;
    } decExec_s;

    // execute -> commit, also the writeback record
    typedef struct packed {
        logic                   valid;
        logic [`DATA_W-1:0]     pc;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   regWrite;
        logic [`DATA_W-1:0]     data;
        logic [1:0]             exc;
    } wbRec_s;

endpackage

`default_nettype wire

//--- source/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_config.svh"

module regFile (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire pipeStagePkg::wbRec_s   wbRec_i,
    input  wire logic [`REG_ADDR_W-1:0] rsAddr_i,
    input  wire logic [`REG_ADDR_W-1:0] rtAddr_i,
    output logic [`DATA_W-1:0]          rsData_o,
    output logic [`DATA_W-1:0]          rtData_o
);
    logic [`DATA_W-1:0] regs [`REG_NUM];
    logic               wrEn;

    // commit only clean results
    assign wrEn = wbRec_i.valid && wbRec_i.regWrite && (wbRec_i.exc == `EXC_NONE);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wbRec_i.dest] <= wbRec_i.data;
        end
    end

    function automatic logic [`DATA_W-1:0] readReg(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) return '0;                                    // $zero
        if (wrEn && (wbRec_i.dest == addr)) return wbRec_i.data;      // write-through
        return regs[addr];
    endfunction

    always_comb begin
        rsData_o = readReg(rsAddr_i);
        rtData_o = readReg(rtAddr_i);
    end

    // decoder must never let a write target $zero
    noZeroWrite: assert property (@(posedge clk) disable iff (rst_i)
        wrEn |-> (wbRec_i.dest != '0))
        else $error("regFile: write committed to register 0");

endmodule

`default_nettype wire

//--- source/instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_config.svh"

module instDecoder (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    input  wire logic                      instValid_i,
    input  wire logic [`DATA_W-1:0]        instPc_i,
    input  wire mipsIsaPkg::instWord_u     instWord_i,
    input  wire pipeStagePkg::wbRec_s      exFwd_i,
    input  wire pipeStagePkg::wbRec_s      wbFwd_i,
    input  wire logic [`DATA_W-1:0]        rsData_i,
    input  wire logic [`DATA_W-1:0]        rtData_i,
    output logic [`REG_ADDR_W-1:0]         rsAddr_o,
    output logic [`REG_ADDR_W-1:0]         rtAddr_o,
    output pipeStagePkg::decExec_s         decRec_o
);
    import mipsIsaPkg::*;
    import pipeStagePkg::*;

    localparam logic [1:0] IMM_SIGN  = 2'd0;
    localparam logic [1:0] IMM_ZERO  = 2'd1;
    localparam logic [1:0] IMM_UPPER = 2'd2;

    aluOp_e                 aluOp;
    brCond_e                brCond;
    logic [1:0]             immKind;
    logic                   useImm, regWrite, link, ovfCheck, riFlag;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`DATA_W-1:0]     immExt, rsVal, rtVal;
    decExec_s               decNext;

    assign rsAddr_o = instWord_i.r.rs;
    assign rtAddr_o = instWord_i.r.rt;

    always_comb begin
        aluOp    = ALU_ADD;
        brCond   = BR_NONE;
        immKind  = IMM_SIGN;
        useImm   = 1'b0;
        regWrite = 1'b0;
        link     = 1'b0;
        ovfCheck = 1'b0;
        riFlag   = 1'b0;
        dest     = instWord_i.r.rd;
        case (instWord_i.r.op)
            OP_SPECIAL: begin
                regWrite = 1'b1;
                case (instWord_i.r.funct)
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    FN_SRA:  aluOp = ALU_SRA;
                    FN_ADD:  begin aluOp = ALU_ADD; ovfCheck = 1'b1; end
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUB:  begin aluOp = ALU_SUB; ovfCheck = 1'b1; end
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_NOR:  aluOp = ALU_NOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    FN_JR:   begin brCond = BR_JREG; regWrite = 1'b0; end
                    default: begin riFlag = 1'b1; regWrite = 1'b0; end
                endcase
            end
            OP_J:    brCond = BR_JUMP;
            OP_JAL:  begin brCond = BR_JUMP; link = 1'b1; regWrite = 1'b1; dest = `REG_LINK; end
            OP_BEQ:  brCond = BR_EQ;
            OP_BNE:  brCond = BR_NE;
            OP_BLEZ: brCond = BR_LEZ;
            OP_BGTZ: brCond = BR_GTZ;
            default: begin
                // immediate forms write rt
                useImm   = 1'b1;
                regWrite = 1'b1;
                dest     = instWord_i.i.rt;
                case (instWord_i.i.op)
                    OP_ADDI:  ovfCheck = 1'b1;
                    OP_ADDIU: aluOp = ALU_ADD;
                    OP_SLTI:  aluOp = ALU_SLT;
                    OP_ANDI:  begin aluOp = ALU_AND; immKind = IMM_ZERO; end
                    OP_ORI:   begin aluOp = ALU_OR;  immKind = IMM_ZERO; end
                    OP_XORI:  begin aluOp = ALU_XOR; immKind = IMM_ZERO; end
                    OP_LUI:   begin aluOp = ALU_PASSB; immKind = IMM_UPPER; end
                    default:  begin riFlag = 1'b1; regWrite = 1'b0; end
                endcase
            end
        endcase
    end

    always_comb begin
        case (immKind)
            IMM_ZERO:  immExt = {{(`DATA_W-16){1'b0}}, instWord_i.i.imm16};
            IMM_UPPER: immExt = {instWord_i.i.imm16, {(`DATA_W-16){1'b0}}};
            default:   immExt = {{(`DATA_W-16){instWord_i.i.imm16[15]}}, instWord_i.i.imm16};
        endcase
    end

    function automatic logic recHits(input wbRec_s rec, input logic [`REG_ADDR_W-1:0] addr);
        return rec.valid && rec.regWrite && (rec.exc == `EXC_NONE) && (rec.dest == addr);
    endfunction

    // execute first, then commit, then regfile
    assign rsVal = recHits(exFwd_i, rsAddr_o) ? exFwd_i.data :
                   recHits(wbFwd_i, rsAddr_o) ? wbFwd_i.data : rsData_i;
    assign rtVal = recHits(exFwd_i, rtAddr_o) ? exFwd_i.data :
                   recHits(wbFwd_i, rtAddr_o) ? wbFwd_i.data : rtData_i;

    always_comb begin
        decNext.pc       = instPc_i;
        decNext.opA      = rsVal;
        decNext.opB      = useImm ? immExt : rtVal;
        decNext.rtVal    = rtVal;
        decNext.aluOp    = aluOp;
        decNext.brCond   = brCond;
        decNext.shamt    = instWord_i.r.shamt;
        decNext.jIndex   = {instWord_i.i.rs, instWord_i.i.rt, instWord_i.i.imm16};
        decNext.imm16    = instWord_i.i.imm16;
        decNext.dest     = dest;
        decNext.regWrite = regWrite && (dest != '0);    // $zero writes dropped here
        decNext.link     = link;
        decNext.ovfCheck = ovfCheck;
        decNext.riFlag   = riFlag;
        decNext.valid    = instValid_i;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            decRec_o.valid <= 1'b0;
        end else begin
            decRec_o <= decNext;
        end
    end

endmodule

`default_nettype wire

//--- source/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_config.svh"

module aluUnit (
    input  wire pipeStagePkg::decExec_s decRec_i,
    output logic [`DATA_W-1:0]          aluResult_o,
    output logic                        overflow_o
);
    import mipsIsaPkg::*;

    localparam int MSB = `DATA_W - 1;

    logic [`DATA_W-1:0] opA, opB, sum, diff;
    logic               addOvf, subOvf;

    assign opA  = decRec_i.opA;
    assign opB  = decRec_i.opB;
    assign sum  = opA + opB;
    assign diff = opA - opB;

    // signed overflow from operand and result signs
    assign addOvf = (opA[MSB] == opB[MSB]) && (sum[MSB] != opA[MSB]);
    assign subOvf = (opA[MSB] != opB[MSB]) && (diff[MSB] != opA[MSB]);

    always_comb begin
        case (decRec_i.aluOp)
            ALU_ADD:   aluResult_o = sum;
            ALU_SUB:   aluResult_o = diff;
            ALU_AND:   aluResult_o = opA & opB;
            ALU_OR:    aluResult_o = opA | opB;
            ALU_XOR:   aluResult_o = opA ^ opB;
            ALU_NOR:   aluResult_o = ~(opA | opB);
            ALU_SLT:   aluResult_o = {{MSB{1'b0}}, $signed(opA) < $signed(opB)};
            ALU_SLTU:  aluResult_o = {{MSB{1'b0}}, opA < opB};
            ALU_SLL:   aluResult_o = opB << decRec_i.shamt;    // shifts act on rt
            ALU_SRL:   aluResult_o = opB >> decRec_i.shamt;
            ALU_SRA:   aluResult_o = $signed(opB) >>> decRec_i.shamt;
            ALU_PASSB: aluResult_o = opB;                      // lui
            default:   aluResult_o = '0;
        endcase
    end

    assign overflow_o = decRec_i.ovfCheck &&
                        ((decRec_i.aluOp == ALU_SUB) ? subOvf : addOvf);

endmodule

`default_nettype wire

//--- source/branchUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_config.svh"

module branchUnit (
    input  wire pipeStagePkg::decExec_s decRec_i,
    output logic                        taken_o,
    output logic [`DATA_W-1:0]          target_o,
    output logic [`DATA_W-1:0]          linkData_o
);
    import mipsIsaPkg::*;

    localparam int MSB = `DATA_W - 1;

    logic [`DATA_W-1:0] rsVal, rtVal, pcPlus4, brOffset, brTarget, jTarget;
    logic               cond;

    assign rsVal    = decRec_i.opA;
    assign rtVal    = decRec_i.rtVal;
    assign pcPlus4  = decRec_i.pc + `DATA_W'd4;
    assign brOffset = {{(`DATA_W-18){decRec_i.imm16[15]}}, decRec_i.imm16, 2'b00};
    assign brTarget = pcPlus4 + brOffset;
    assign jTarget  = {pcPlus4[MSB -: 4], decRec_i.jIndex, 2'b00};   // same 256MB region

    always_comb begin
        case (decRec_i.brCond)
            BR_EQ:   cond = (rsVal == rtVal);
            BR_NE:   cond = (rsVal != rtVal);
            BR_LEZ:  cond = rsVal[MSB] || (rsVal == '0);
            BR_GTZ:  cond = !rsVal[MSB] && (rsVal != '0);
            BR_JUMP: cond = 1'b1;
            BR_JREG: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign taken_o    = decRec_i.valid && cond;
    assign target_o   = (decRec_i.brCond == BR_JUMP) ? jTarget :
                        (decRec_i.brCond == BR_JREG) ? rsVal : brTarget;
    assign linkData_o = decRec_i.pc + `DATA_W'd8;     // skips the delay slot

endmodule

`default_nettype wire

//--- source/commitStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_config.svh"

module commitStage (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire pipeStagePkg::decExec_s decRec_i,
    input  wire logic [`DATA_W-1:0]     aluResult_i,
    input  wire logic                   overflow_i,
    input  wire logic                   taken_i,
    input  wire logic [`DATA_W-1:0]     target_i,
    input  wire logic [`DATA_W-1:0]     linkData_i,
    output pipeStagePkg::wbRec_s        exFwd_o,
    output pipeStagePkg::wbRec_s        wbRec_o,
    output logic                        branchTaken_o,
    output logic [`DATA_W-1:0]          branchTarget_o
);
    always_comb begin
        exFwd_o.valid    = decRec_i.valid;
        exFwd_o.pc       = decRec_i.pc;
        exFwd_o.dest     = decRec_i.dest;
        exFwd_o.regWrite = decRec_i.regWrite;
        exFwd_o.data     = decRec_i.link ? linkData_i : aluResult_i;
        if (decRec_i.riFlag) begin
            exFwd_o.exc = `EXC_RI;
        end else if (overflow_i) begin
            exFwd_o.exc = `EXC_OVF;
        end else begin
            exFwd_o.exc = `EXC_NONE;
        end
    end

    // redirect leaves in the execute cycle
    assign branchTaken_o  = taken_i;
    assign branchTarget_o = target_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wbRec_o.valid <= 1'b0;
        end else begin
            wbRec_o <= exFwd_o;
        end
    end

    // a reserved instruction never reaches the alu with an overflow check
    riNotOvf: assert property (@(posedge clk) disable iff (rst_i)
        (decRec_i.valid && decRec_i.riFlag) |-> !overflow_i)
        else $error("commitStage: overflow raised for a reserved instruction");

endmodule

`default_nettype wire

//--- source/mipsLiteCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_config.svh"

module mipsLiteCore (
    input  wire logic                  clk,
    input  wire logic                  rst_i,
    input  wire logic                  instValid_i,
    input  wire logic [`DATA_W-1:0]    instPc_i,
    input  wire mipsIsaPkg::instWord_u instWord_i,
    output logic                       wbValid_o,
    output logic [`DATA_W-1:0]         wbPc_o,
    output logic                       wbRegWen_o,
    output logic [`REG_ADDR_W-1:0]     wbRegNum_o,
    output logic [`DATA_W-1:0]         wbData_o,
    output logic [1:0]                 wbExc_o,
    output logic                       branchTaken_o,
    output logic [`DATA_W-1:0]         branchTarget_o
);
    import pipeStagePkg::*;

    decExec_s               decRec;
    wbRec_s                 exFwd, wbRec;
    logic [`REG_ADDR_W-1:0] rsAddr, rtAddr;
    logic [`DATA_W-1:0]     rsData, rtData, aluResult, target, linkData;
    logic                   overflow, taken;

    regFile i_regFile (
        .clk(clk), .rst_i(rst_i), .wbRec_i(wbRec),
        .rsAddr_i(rsAddr), .rtAddr_i(rtAddr), .rsData_o(rsData), .rtData_o(rtData)
    );

    instDecoder i_instDecoder (
        .clk(clk), .rst_i(rst_i),
        .instValid_i(instValid_i), .instPc_i(instPc_i), .instWord_i(instWord_i),
        .exFwd_i(exFwd), .wbFwd_i(wbRec), .rsData_i(rsData), .rtData_i(rtData),
        .rsAddr_o(rsAddr), .rtAddr_o(rtAddr), .decRec_o(decRec)
    );

    aluUnit i_aluUnit (.decRec_i(decRec), .aluResult_o(aluResult), .overflow_o(overflow));

    branchUnit i_branchUnit (
        .decRec_i(decRec), .taken_o(taken), .target_o(target), .linkData_o(linkData)
    );

    commitStage i_commitStage (
        .clk(clk), .rst_i(rst_i), .decRec_i(decRec),
        .aluResult_i(aluResult), .overflow_i(overflow),
        .taken_i(taken), .target_i(target), .linkData_i(linkData),
        .exFwd_o(exFwd), .wbRec_o(wbRec),
        .branchTaken_o(branchTaken_o), .branchTarget_o(branchTarget_o)
    );

    // debug-style writeback view of the commit record
    assign wbValid_o  = wbRec.valid;
    assign wbPc_o     = wbRec.pc;
    assign wbRegWen_o = wbRec.valid && wbRec.regWrite && (wbRec.exc == `EXC_NONE);
    assign wbRegNum_o = wbRec.dest;
    assign wbData_o   = wbRec.data;
    assign wbExc_o    = wbRec.exc;

endmodule

`default_nettype wire

//--- verif/mipsLiteCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_config.svh"

module mipsLiteCoreTb;
    import mipsIsaPkg::*;
    import pipeStagePkg::*;

    localparam int CLK_HALF  = 4;
    localparam int DRAIN_MAX = 16;    // cycles allowed past the last pattern line

    logic                   clk;
    logic                   rst_i;
    logic                   instValid;
    logic [`DATA_W-1:0]     instPc;
    instWord_u              instWord;
    logic                   wbValid, wbRegWen, branchTaken;
    logic [`DATA_W-1:0]     wbPc, wbData, branchTarget;
    logic [`REG_ADDR_W-1:0] wbRegNum;
    logic [1:0]             wbExc;

    // pattern columns, one entry per line
    logic [7:0]         kindQ[$];
    logic [`DATA_W-1:0] pcQ[$], wordQ[$], colA[$], colB[$], colC[$], colD[$];

    // expected results in flight, with the cycle they are due
    int                 wbDue[$], wbTest[$], brDue[$], brTest[$];
    wbRec_s             wbExp[$];
    logic               brTakenExp[$];
    logic [`DATA_W-1:0] brTargetExp[$];

    int testErr[];
    int errCount    = 0;
    int nTests      = 0;
    int failedTests = 0;
    int cyc         = 0;

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    mipsLiteCore i_mipsLiteCore (
        .clk(clk), .rst_i(rst_i),
        .instValid_i(instValid), .instPc_i(instPc), .instWord_i(instWord),
        .wbValid_o(wbValid), .wbPc_o(wbPc), .wbRegWen_o(wbRegWen), .wbRegNum_o(wbRegNum),
        .wbData_o(wbData), .wbExc_o(wbExc),
        .branchTaken_o(branchTaken), .branchTarget_o(branchTarget)
    );

    task automatic noteError(input int test);
        errCount++;
        if (test >= 0) testErr[test]++;
    endtask

    task automatic compareValue(input int test, input string name,
                                input logic [`DATA_W-1:0] expVal, input logic [`DATA_W-1:0] actVal);
        if (actVal !== expVal) begin
            $display("FAILED test %0d %s: expected %h, got %h", test, name, expVal, actVal);
            noteError(test);
        end
    endtask

    task automatic checkWb(input int test, input wbRec_s exp, input wbRec_s act);
        compareValue(test, "wbValid_o", exp.valid, act.valid);
        compareValue(test, "wbPc_o", exp.pc, act.pc);
        compareValue(test, "wbRegWen_o", exp.regWrite, act.regWrite);
        compareValue(test, "wbExc_o", exp.exc, act.exc);
        if (exp.regWrite) begin    // number and data only mean something on a commit
            compareValue(test, "wbRegNum_o", exp.dest, act.dest);
            compareValue(test, "wbData_o", exp.data, act.data);
        end
    endtask

    task automatic checkBranch(input int test, input logic expTaken,
                               input logic [`DATA_W-1:0] expTarget,
                               input logic actTaken, input logic [`DATA_W-1:0] actTarget);
        compareValue(test, "branchTaken_o", expTaken, actTaken);
        if (expTaken) compareValue(test, "branchTarget_o", expTarget, actTarget);
    endtask

    task automatic reportTest(input int test);
        if (testErr[test] == 0) begin
            $display("test %0d (%c) pc %h passed", test, kindQ[test], pcQ[test]);
        end else begin
            $display("test %0d (%c) pc %h failed, %0d mismatches",
                     test, kindQ[test], pcQ[test], testErr[test]);
            failedTests++;
        end
    endtask

    task automatic loadPatterns();
        int                 fd;
        int                 n;
        logic [8*160-1:0]   line;
        logic [8*8-1:0]     kind;
        logic [`DATA_W-1:0] pc, word, a, b, c, d;
        fd = $fopen("verif/corePatterns.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/corePatterns.txt");
            noteError(-1);
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %h %h %h %h %h %h", kind, pc, word, a, b, c, d);
                if (n == 7) begin    // comment and blank lines fall through
                    if (!(kind[7:0] inside {"W", "B", "L", "N"})) begin
                        $display("pattern file holds an unknown line kind");
                        noteError(-1);
                    end else begin
                        kindQ.push_back(kind[7:0]);
                        pcQ.push_back(pc);
                        wordQ.push_back(word);
                        colA.push_back(a);
                        colB.push_back(b);
                        colC.push_back(c);
                        colD.push_back(d);
                    end
                end
            end
            $fclose(fd);
        end
        testErr = new[kindQ.size()];
    endtask

    task automatic queueBranch(input int test, input logic taken, input logic [`DATA_W-1:0] tgt);
        brDue.push_back(cyc + 1);    // redirect shows one edge after acceptance
        brTest.push_back(test);
        brTakenExp.push_back(taken);
        brTargetExp.push_back(tgt);
    endtask

    task automatic driveLine(input int idx);
        wbRec_s exp;
        instPc    = pcQ[idx];
        instWord  = wordQ[idx];
        instValid = (kindQ[idx] != "N");
        if (kindQ[idx] != "N") begin
            nTests++;
            exp.valid = 1'b1;
            exp.pc    = pcQ[idx];
            exp.exc   = `EXC_NONE;
            case (kindQ[idx])
                "W": begin
                    exp.dest     = colA[idx][`REG_ADDR_W-1:0];
                    exp.data     = colB[idx];
                    exp.regWrite = colC[idx][0];
                    exp.exc      = colD[idx][1:0];
                end
                "B": begin
                    exp.dest     = '0;
                    exp.data     = '0;
                    exp.regWrite = 1'b0;
                    queueBranch(idx, colA[idx][0], colB[idx]);
                end
                default: begin    // jal, redirect plus link write
                    exp.dest     = `REG_LINK;
                    exp.data     = colB[idx];
                    exp.regWrite = 1'b1;
                    queueBranch(idx, 1'b1, colA[idx]);
                end
            endcase
            wbDue.push_back(cyc + 2);
            wbTest.push_back(idx);
            wbExp.push_back(exp);
        end
    endtask

    task automatic checkDueResults();
        wbRec_s act;
        if (brDue.size() != 0 && brDue[0] == cyc) begin
            checkBranch(brTest[0], brTakenExp[0], brTargetExp[0], branchTaken, branchTarget);
            void'(brDue.pop_front());
            void'(brTest.pop_front());
            void'(brTakenExp.pop_front());
            void'(brTargetExp.pop_front());
        end else if (branchTaken !== 1'b0) begin
            $display("branch redirect at cycle %0d with no branch in flight", cyc);
            noteError(-1);
        end
        act.valid    = wbValid;
        act.pc       = wbPc;
        act.dest     = wbRegNum;
        act.regWrite = wbRegWen;
        act.data     = wbData;
        act.exc      = wbExc;
        if (wbDue.size() != 0 && wbDue[0] == cyc) begin
            checkWb(wbTest[0], wbExp[0], act);
            reportTest(wbTest[0]);
            void'(wbDue.pop_front());
            void'(wbTest.pop_front());
            void'(wbExp.pop_front());
        end else if (wbValid !== 1'b0) begin
            $display("writeback at cycle %0d with no instruction in flight", cyc);
            noteError(-1);
        end
    endtask

    initial begin
        int idx;
        int limit;
        rst_i     = 1'b1;
        instValid = 1'b0;
        instPc    = '0;
        instWord  = '0;
        loadPatterns();
        if (kindQ.size() == 0) begin
            $display("pattern file holds no test lines");
            noteError(-1);
        end
        limit = kindQ.size() + DRAIN_MAX;
        repeat (4) @(posedge clk);
        #1 rst_i = 1'b0;
        idx = 0;
        while (idx < kindQ.size() || wbDue.size() != 0 || brDue.size() != 0) begin
            @(posedge clk);
            #1;
            cyc++;
            if (cyc > limit) begin
                $display("timeout, the pipeline did not drain");
                noteError(-1);
                break;
            end
            checkDueResults();    // outputs settled since the edge
            if (idx < kindQ.size()) begin
                driveLine(idx);
                idx++;
            end else begin
                instValid = 1'b0;
                instWord  = '0;
            end
        end
        $display("tests %0d, failed %0d, mismatches %0d", nTests, failedTests, errCount);
        if (errCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/corePatterns.txt
# kind pc instr col1 col2 col3 col4, all hex
# W rows: reg data wen exc / B rows: taken target / L rows: target link / N rows: bubble
W 00000100 00430820 01 00000000 1 0
W 00000104 24011234 01 00001234 1 0
W 00000108 3402F0F0 02 0000F0F0 1 0
W 0000010C 3C038000 03 80000000 1 0
W 00000110 2024FFFC 04 00001230 1 0
W 00000114 00822822 05 FFFF2140 1 0
W 00000118 00A23024 06 00002040 1 0
W 0000011C 00A63826 07 FFFF0100 1 0
W 00000120 00E04027 08 0000FEFF 1 0
W 00000124 00A4482A 09 00000001 1 0
W 00000128 00A4502B 0A 00000000 1 0
W 0000012C 00065900 0B 00020400 1 0
W 00000130 00036203 0C FF800000 1 0
W 00000134 00036A02 0D 00800000 1 0
W 00000138 30AEFF00 0E 00002100 1 0
W 0000013C 388FFFFF 0F 0000EDCF 1 0
W 00000140 28B0FFFF 10 00000001 1 0
W 00000144 00048823 11 FFFFEDD0 1 0
W 00000148 00631820 03 00000000 0 1
W 0000014C 2061FFFF 01 00000000 0 1
W 00000150 00629022 12 00000000 0 1
W 00000154 00619825 13 80001234 1 0
W 00000158 FC000000 00 00000000 0 2
N 00000000 00000000 0 0 0 0
B 00000200 10210004 1 00000214 0 0
B 00000204 14210004 0 00000000 0 0
B 00000208 18A0FFFE 1 00000204 0 0
B 0000020C 1CA0FFFE 0 00000000 0 0
B 00000210 1C800010 1 00000254 0 0
B 00000214 08000100 1 00000400 0 0
B 00000218 00200008 1 00001234 0 0
L 0000021C 0C000200 00000800 00000224 0 0
W 00000220 03E0A021 14 00000224 1 0

//--- tb.f
+incdir+source
source/mipsIsaPkg.sv
source/pipeStagePkg.sv
source/regFile.sv
source/instDecoder.sv
source/aluUnit.sv
source/branchUnit.sv
source/commitStage.sv
source/mipsLiteCore.sv
verif/mipsLiteCoreTb.sv
